// File: Makefile
TOP = page_system_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o vsim
	obj_dir/vsim > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Test failures found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: hw/page_list_mgr.sv
// num_pages from 4 to 256 and head_depth of at least 2; link and free ports always accept
`timescale 1ns/1ps

module page_list_mgr #(
  parameter int num_pages  = 16,
  parameter int head_depth = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                alloc_srdy,
  output logic                alloc_drdy,
  output logic [7:0]          alloc_page,
  input  logic                lnk_srdy,
  output logic                lnk_drdy,
  input  logic [7:0]          lnk_page,
  input  pm_pkg::link_entry_t lnk_entry,
  input  logic                hq_in_srdy,
  output logic                hq_in_drdy,
  input  logic [7:0]          hq_in_page,
  output logic                hq_out_srdy,
  input  logic                hq_out_drdy,
  output logic [7:0]          hq_out_page,
  input  logic [7:0]          rd_page,
  output pm_pkg::link_entry_t rd_entry,
  input  logic                free_srdy,
  output logic                free_drdy,
  input  logic [7:0]          free_page
);
  import pm_pkg::*;

  localparam int idx_w = $clog2(num_pages);
  localparam int fc_w  = $clog2(num_pages + 1);
  localparam int hq_aw = $clog2(head_depth);
  localparam int hq_cw = $clog2(head_depth + 1);
  localparam logic [idx_w-1:0] last_slot = idx_w'(num_pages - 1);
  localparam logic [fc_w-1:0]  pool_full = fc_w'(num_pages);
  localparam logic [hq_aw-1:0] hq_last   = hq_aw'(head_depth - 1);
  localparam logic [hq_cw-1:0] hq_full   = hq_cw'(head_depth);

  logic [PAGE_W-1:0] free_mem [num_pages];
  logic [idx_w-1:0]  free_rd;
  logic [idx_w-1:0]  free_wr;
  logic [fc_w-1:0]   free_cnt;
  link_entry_t       link_mem [num_pages];
  logic [PAGE_W-1:0] hq_mem [head_depth];
  logic [hq_aw-1:0]  hq_rd;
  logic [hq_aw-1:0]  hq_wr;
  logic [hq_cw-1:0]  hq_cnt;
  logic [num_pages-1:0] page_alloc;
  logic              alloc_xfer;
  logic              free_xfer;
  logic              push_xfer;
  logic              pop_xfer;

  assign alloc_drdy  = (free_cnt != '0);
  assign alloc_page  = free_mem[free_rd];
  // fifo holds every page, so a returned page always fits
  assign free_drdy   = 1'b1;
  assign lnk_drdy    = 1'b1;
  assign hq_in_drdy  = (hq_cnt != hq_full);
  assign hq_out_srdy = (hq_cnt != '0);
  assign hq_out_page = hq_mem[hq_rd];

  assign alloc_xfer = alloc_srdy && alloc_drdy;
  assign free_xfer  = free_srdy && free_drdy;
  assign push_xfer  = hq_in_srdy && hq_in_drdy;
  assign pop_xfer   = hq_out_srdy && hq_out_drdy;

  // free list loaded with 0..num_pages-1 on reset
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      for (int i = 0; i < num_pages; i++)
        free_mem[i] <= PAGE_W'(i);
      free_rd  <= '0;
      free_wr  <= '0;
      free_cnt <= pool_full;
    end
    else
    begin
      if (free_xfer)
      begin
        free_mem[free_wr] <= free_page;
        free_wr <= (free_wr == last_slot) ? '0 : free_wr + 1'b1;
      end
      if (alloc_xfer)
        free_rd <= (free_rd == last_slot) ? '0 : free_rd + 1'b1;
      if (alloc_xfer && !free_xfer)
        free_cnt <= free_cnt - 1'b1;
      else if (free_xfer && !alloc_xfer)
        free_cnt <= free_cnt + 1'b1;
    end
  end

  // link and tag store with read data one cycle after rd_page
  always_ff @(posedge clk)
  begin
    if (lnk_srdy && lnk_drdy)
      link_mem[lnk_page[idx_w-1:0]] <= lnk_entry;
    rd_entry <= link_mem[rd_page[idx_w-1:0]];
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      hq_rd  <= '0;
      hq_wr  <= '0;
      hq_cnt <= '0;
    end
    else
    begin
      if (push_xfer)
        hq_wr <= (hq_wr == hq_last) ? '0 : hq_wr + 1'b1;
      if (pop_xfer)
        hq_rd <= (hq_rd == hq_last) ? '0 : hq_rd + 1'b1;
      if (push_xfer && !pop_xfer)
        hq_cnt <= hq_cnt + 1'b1;
      else if (pop_xfer && !push_xfer)
        hq_cnt <= hq_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_xfer)
      hq_mem[hq_wr] <= hq_in_page;
  end

  // pages currently owned by the writer or reader
  always_ff @(posedge clk)
  begin
    if (!reset)
      page_alloc <= '0;
    else
    begin
      if (alloc_xfer)
        page_alloc[alloc_page[idx_w-1:0]] <= 1'b1;
      if (free_xfer)
        page_alloc[free_page[idx_w-1:0]] <= 1'b0;
    end
  end

  // reader returns only pages it took from a chain
  a_free_not_full: assert property (@(posedge clk) disable iff (!reset)
    free_xfer |-> (free_cnt != pool_full));

  // a handed-out page must be unowned and so can never come from an empty list
  a_alloc_from_free: assert property (@(posedge clk) disable iff (!reset)
    alloc_xfer |-> !page_alloc[alloc_page[idx_w-1:0]]);

  a_link_owned_page: assert property (@(posedge clk) disable iff (!reset)
    (lnk_srdy && lnk_drdy) |-> page_alloc[lnk_page[idx_w-1:0]]);

endmodule

// File: hw/page_reader.sv
// two cycles per page; a stalled beat keeps its page out of the free list
`timescale 1ns/1ps

module page_reader (
  input  logic                clk,
  input  logic                reset,
  input  logic                hq_out_srdy,
  output logic                hq_out_drdy,
  input  logic [7:0]          hq_out_page,
  output logic [7:0]          rd_page,
  input  pm_pkg::link_entry_t rd_entry,
  output logic                free_srdy,
  input  logic                free_drdy,
  output logic [7:0]          free_page,
  output logic                out_srdy,
  input  logic                out_drdy,
  output pm_pkg::out_beat_t   out
);
  import pm_pkg::*;

  typedef enum logic [1:0] {st_idle, st_read, st_beat} state_t;

  state_t            state;
  logic [PAGE_W-1:0] cur_page;
  logic [1:0]        idx_q;
  logic              out_xfer;

  assign hq_out_drdy = (state == st_idle);
  // address stays on cur_page so rd_entry holds steady during a stall
  assign rd_page     = cur_page;
  assign free_page   = cur_page;
  // beat and free complete together
  assign out_srdy    = (state == st_beat) && free_drdy;
  assign free_srdy   = (state == st_beat) && out_drdy;
  assign out_xfer    = out_srdy && out_drdy;

  always_comb
  begin
    out.tag  = rd_entry.tag;
    out.page = cur_page;
    out.idx  = idx_q;
    out.last = rd_entry.stop;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:
          if (hq_out_srdy)
            state <= st_read;
        st_read:
          state <= st_beat;
        st_beat:
          if (out_xfer)
            state <= rd_entry.stop ? st_idle : st_read;
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (hq_out_srdy && hq_out_drdy)
    begin
      cur_page <= hq_out_page;
      idx_q    <= 2'd0;
    end
    else if (out_xfer)
    begin
      // follow the chain
      cur_page <= rd_entry.next;
      idx_q    <= idx_q + 2'd1;
    end
  end

  // writer never builds a chain longer than four pages
  a_idx_no_wrap: assert property (@(posedge clk) disable iff (!reset)
    (out_xfer && !rd_entry.stop) |-> (idx_q != 2'd3));

endmodule

// File: hw/page_system.sv
// single writer and single reader; beats leave in command order, latency depends on pool use
`timescale 1ns/1ps

module page_system #(
  parameter int num_pages  = 16,
  parameter int head_depth = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_srdy,
  output logic              cmd_drdy,
  input  pm_pkg::page_cmd_t cmd,
  output logic              out_srdy,
  input  logic              out_drdy,
  output pm_pkg::out_beat_t out
);
  import pm_pkg::*;

  logic              alloc_srdy;
  logic              alloc_drdy;
  logic [PAGE_W-1:0] alloc_page;
  logic              lnk_srdy;
  logic              lnk_drdy;
  logic [PAGE_W-1:0] lnk_page;
  link_entry_t       lnk_entry;
  logic              hq_in_srdy;
  logic              hq_in_drdy;
  logic [PAGE_W-1:0] hq_in_page;
  logic              hq_out_srdy;
  logic              hq_out_drdy;
  logic [PAGE_W-1:0] hq_out_page;
  logic [PAGE_W-1:0] rd_page;
  link_entry_t       rd_entry;
  logic              free_srdy;
  logic              free_drdy;
  logic [PAGE_W-1:0] free_page;

  page_writer page_writer_inst (.*);

  page_list_mgr #(
    .num_pages  (num_pages),
    .head_depth (head_depth)
  ) page_list_mgr_inst (.*);

  page_reader page_reader_inst (.*);

endmodule

// File: hw/page_writer.sv
// one command in flight at a time; stalls in allocation while the free list is empty
`timescale 1ns/1ps

module page_writer (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_srdy,
  output logic               cmd_drdy,
  input  pm_pkg::page_cmd_t  cmd,
  output logic               alloc_srdy,
  input  logic               alloc_drdy,
  input  logic [7:0]         alloc_page,
  output logic               lnk_srdy,
  input  logic               lnk_drdy,
  output logic [7:0]         lnk_page,
  output pm_pkg::link_entry_t lnk_entry,
  output logic               hq_in_srdy,
  input  logic               hq_in_drdy,
  output logic [7:0]         hq_in_page
);
  import pm_pkg::*;

  typedef enum logic [1:0] {st_idle, st_alloc, st_link, st_push} state_t;

  state_t            state;
  logic [7:0]        tag_q;
  logic [2:0]        left_q;
  logic              first_q;
  logic [PAGE_W-1:0] head_q;
  logic [PAGE_W-1:0] prev_q;
  logic              lnk_busy;
  logic              alloc_xfer;

  // a link write still waiting holds back the next allocation
  assign lnk_busy   = lnk_srdy && !lnk_drdy;
  assign cmd_drdy   = (state == st_idle);
  assign alloc_srdy = (state == st_alloc) && !lnk_busy;
  assign alloc_xfer = alloc_srdy && alloc_drdy;
  // head goes out only once the stop word is in memory
  assign hq_in_srdy = (state == st_push) && !lnk_srdy;
  assign hq_in_page = head_q;

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      state    <= st_idle;
      lnk_srdy <= 1'b0;
      left_q   <= 3'd0;
      first_q  <= 1'b0;
    end
    else
    begin
      if (lnk_srdy && lnk_drdy)
        lnk_srdy <= 1'b0;
      case (state)
        st_idle:
          if (cmd_srdy)
          begin
            left_q  <= cmd_pages(cmd.len);
            first_q <= 1'b1;
            state   <= st_alloc;
          end
        st_alloc:
          if (alloc_xfer)
          begin
            first_q <= 1'b0;
            left_q  <= left_q - 3'd1;
            // previous page now knows its successor
            if (!first_q)
              lnk_srdy <= 1'b1;
            if (left_q == 3'd1)
              state <= st_link;
          end
        st_link:
          if (!lnk_busy)
          begin
            lnk_srdy <= 1'b1;
            state    <= st_push;
          end
        st_push:
          if (hq_in_srdy && hq_in_drdy)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_srdy && cmd_drdy)
      tag_q <= cmd.tag;
    if (alloc_xfer)
    begin
      prev_q <= alloc_page;
      if (first_q)
        head_q <= alloc_page;
      else
      begin
        lnk_page  <= prev_q;
        lnk_entry <= link_to(alloc_page, tag_q);
      end
    end
    // last page of the chain gets the stop word
    if ((state == st_link) && !lnk_busy)
    begin
      lnk_page  <= prev_q;
      lnk_entry <= stop_link(tag_q);
    end
  end

endmodule

// File: hw/pm_pkg.sv
// page numbers are 8 bits wide, so a pool holds at most 256 pages; a packet spans 1 to 4 pages
package pm_pkg;

  // width of a page number in every struct and port
  localparam int PAGE_W = 8;

  // packet command; len of 0 stands for four pages
  typedef struct packed {
    logic [7:0] tag;
    logic [1:0] len;
  } page_cmd_t;

  // one link memory word
  // when stop is set the chain ends here and next carries no meaning
  typedef struct packed {
    logic              stop;
    logic [PAGE_W-1:0] next;
    logic [7:0]        tag;
  } link_entry_t;

  // one output beat per page
  typedef struct packed {
    logic [7:0]        tag;
    logic [PAGE_W-1:0] page;
    logic [1:0]        idx;
    logic              last;
  } out_beat_t;

  // pages needed by a command
  function automatic logic [2:0] cmd_pages(input logic [1:0] len);
    return (len == 2'd0) ? 3'd4 : {1'b0, len};
  endfunction

  // link word pointing at the following page of a chain
  function automatic link_entry_t link_to(input logic [PAGE_W-1:0] next,
                                          input logic [7:0] tag);
    return '{stop: 1'b0, next: next, tag: tag};
  endfunction

  // stop word with a set flag over an all-zero page number
  function automatic link_entry_t stop_link(input logic [7:0] tag);
    return '{stop: 1'b1, next: '0, tag: tag};
  endfunction

endpackage

// File: sim.f
hw/pm_pkg.sv
hw/page_writer.sv
hw/page_list_mgr.sv
hw/page_reader.sv
hw/page_system.sv
tests/page_checker.sv
tests/page_system_tb.sv

// File: tests/page_checker.sv
// expects beats in command order; page range check assumes the pool is numbered from 0
`timescale 1ns/1ps

module page_checker #(
  parameter int num_pages = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_srdy,
  input  logic              cmd_drdy,
  input  pm_pkg::page_cmd_t cmd,
  input  logic              out_srdy,
  input  logic              out_drdy,
  input  pm_pkg::out_beat_t out,
  input  logic              end_check,
  output int                pass_count,
  output int                fail_count,
  output int                pending
);
  import pm_pkg::*;

  typedef struct packed {
    logic [7:0] tag;
    logic [1:0] idx;
    logic       last;
  } exp_beat_t;

  exp_beat_t    exp_q [$];
  logic [255:0] used;
  logic         pkt_bad;
  int           pkt_num;
  int           total_beats;

  initial
  begin
    pass_count  = 0;
    fail_count  = 0;
    pending     = 0;
    used        = '0;
    pkt_bad     = 1'b0;
    pkt_num     = 0;
    total_beats = 0;
  end

  task automatic add_command(input page_cmd_t c);
    int n;
    exp_beat_t e;
    n = (c.len == 2'd0) ? 4 : int'(c.len);
    for (int i = 0; i < n; i++)
    begin
      e.tag  = c.tag;
      e.idx  = 2'(i);
      e.last = (i == n - 1);
      exp_q.push_back(e);
    end
  endtask

  task automatic report_field(input string name, input logic [7:0] got, input logic [7:0] want);
    $display("[ERROR] %s got 0x%h expected 0x%h in packet %0d", name, got, want, pkt_num);
    pkt_bad = 1'b1;
  endtask

  task automatic close_packet(input logic [7:0] tag);
    $display("packet %0d tag 0x%h: %s", pkt_num, tag, pkt_bad ? "FAIL" : "ok");
    if (pkt_bad)
      fail_count++;
    else
      pass_count++;
    pkt_num++;
    pkt_bad = 1'b0;
    used    = '0;
  endtask

  task automatic check_beat(input out_beat_t b);
    exp_beat_t e;
    if (exp_q.size() == 0)
    begin
      $display("beat for page %0d arrived with no command outstanding", b.page);
      fail_count++;
      return;
    end
    e = exp_q.pop_front();
    if (b.tag !== e.tag)
      report_field("out.tag", b.tag, e.tag);
    if (b.idx !== e.idx)
      report_field("out.idx", 8'(b.idx), 8'(e.idx));
    if (b.last !== e.last)
      report_field("out.last", 8'(b.last), 8'(e.last));
    // reset fill hands out pages 0, 1, 2 ... to the first packet
    if (pkt_num == 0 && b.page !== 8'(e.idx))
      report_field("out.page", b.page, 8'(e.idx));
    if (b.page >= num_pages || used[b.page])
    begin
      $display("[ERROR] out.page got 0x%h, outside pool or repeated in packet %0d",
               b.page, pkt_num);
      pkt_bad = 1'b1;
    end
    used[b.page] = 1'b1;
    total_beats++;
    if (e.last)
      close_packet(e.tag);
  endtask

  always @(posedge clk)
  begin
    if (reset && cmd_srdy && cmd_drdy)
      add_command(cmd);
    if (reset && out_srdy && out_drdy)
      check_beat(out);
    pending = exp_q.size();
  end

  always @(posedge end_check)
  begin
    if (exp_q.size() != 0)
    begin
      $display("%0d expected beats never arrived", exp_q.size());
      fail_count++;
    end
    // more pages than the pool holds means freed pages came back
    if (pkt_num < 20 || total_beats <= num_pages)
    begin
      $display("recycling: only %0d pages used over %0d packets", total_beats, pkt_num);
      fail_count++;
    end
    else
      $display("recycling: %0d pages used from a pool of %0d", total_beats, num_pages);
  end

endmodule

// File: tests/page_system_tb.sv
// runs on an 8-page pool so exhaustion is reachable; held output rows rely on the pool running dry
`timescale 1ns/1ps

module page_system_tb;
  import pm_pkg::*;

  localparam int pool_pages      = 8;
  localparam int n_rows          = 24;
  localparam int half_period     = 50;
  localparam int stall_limit     = 40;
  localparam int drain_limit     = 400;
  localparam int watchdog_cycles = n_rows * 4 * 20 + 200;
  localparam logic [1:0] m_rdy   = 2'd0;
  localparam logic [1:0] m_rnd   = 2'd1;
  localparam logic [1:0] m_hold  = 2'd2;

  typedef struct packed {
    logic [7:0] tag;
    logic [1:0] len;
    logic [1:0] mode;
  } row_t;

  // tag, len (0 means four pages), out_drdy mode
  row_t rows [n_rows] = '{
    '{8'ha0, 2'd0, m_rdy}, '{8'ha1, 2'd1, m_rdy}, '{8'ha2, 2'd2, m_rdy}, '{8'ha3, 2'd3, m_rdy},
    '{8'hb0, 2'd2, m_rnd}, '{8'hb1, 2'd0, m_rnd}, '{8'hb2, 2'd1, m_rnd}, '{8'hb3, 2'd3, m_rnd},
    '{8'hb4, 2'd0, m_rnd}, '{8'hb5, 2'd1, m_rnd}, '{8'hb6, 2'd2, m_rnd}, '{8'hb7, 2'd3, m_rnd},
    '{8'hc0, 2'd0, m_hold}, '{8'hc1, 2'd0, m_hold}, '{8'hc2, 2'd3, m_hold},
    '{8'hc3, 2'd1, m_hold},
    '{8'hd0, 2'd1, m_rnd}, '{8'hd1, 2'd3, m_rnd}, '{8'hd2, 2'd0, m_rdy}, '{8'hd3, 2'd2, m_rnd},
    '{8'hd4, 2'd0, m_rnd}, '{8'hd5, 2'd1, m_rdy}, '{8'hd6, 2'd3, m_rnd}, '{8'hd7, 2'd2, m_rdy}
  };

  logic       clk;
  logic       reset;
  logic       cmd_srdy;
  logic       cmd_drdy;
  page_cmd_t  cmd;
  logic       out_srdy;
  logic       out_drdy;
  out_beat_t  out;
  logic       end_check;
  int         pass_count;
  int         fail_count;
  int         pending;
  int         seed = 90400;
  int         total_fails;
  logic [1:0] drdy_mode;
  logic       stall_seen;

  page_system #(
    .num_pages  (pool_pages),
    .head_depth (4)
  ) page_system_inst (.*);

  page_checker #(.num_pages(pool_pages)) page_checker_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever
      #(half_period) clk = ~clk;
  end

  // mode is picked up at the rising edge, applied at the falling edge
  initial
  begin
    logic [1:0] mode_now;
    out_drdy = 1'b0;
    forever
    begin
      @(posedge clk);
      mode_now = drdy_mode;
      @(negedge clk);
      if (mode_now == m_rnd)
        out_drdy = 1'($random(seed));
      else
        out_drdy = (mode_now == m_rdy);
    end
  end

  task automatic send_row(input row_t r);
    int waited;
    waited = 0;
    if (r.mode != m_hold || !stall_seen)
      drdy_mode = r.mode;
    cmd_srdy = 1'b1;
    cmd.tag  = r.tag;
    cmd.len  = r.len;
    while (!cmd_drdy)
    begin
      @(negedge clk);
      waited++;
      // pool ran dry with output held, so let the reader drain
      if (drdy_mode == m_hold && waited == stall_limit)
      begin
        $display("exhaustion: command port held low for %0d cycles, output released", waited);
        stall_seen = 1'b1;
        drdy_mode  = m_rnd;
      end
    end
    @(negedge clk);
    cmd_srdy = 1'b0;
  endtask

  initial
  begin
    reset      = 1'b0;
    cmd_srdy   = 1'b0;
    cmd        = '0;
    drdy_mode  = m_rdy;
    end_check  = 1'b0;
    stall_seen = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < n_rows; i++)
      send_row(rows[i]);
    for (int t = 0; t < drain_limit && pending != 0; t++)
      @(negedge clk);
    if (!stall_seen)
      $display("exhaustion: command port never stalled while the output was held");
    end_check = 1'b1;
    @(negedge clk);
    total_fails = fail_count + (stall_seen ? 0 : 1);
    $display("%0d packets passed, %0d failures", pass_count, total_fails);
    if (total_fails == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d clock periods", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule
